// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [1:0]   token_t;

    localparam int ROUND_W = 4;
    localparam logic [ROUND_W-1:0] NUM_ROUNDS = 4'd10;
    localparam logic [7:0] RCON_FIRST = 8'h01;

    // Request handed from decode to the round engine
    typedef struct packed {
        block_t plaintext;
        block_t key;
    } aes_req_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } dec_state_e;

    typedef enum logic {
        ENG_IDLE,
        ENG_ROUND
    } eng_state_e;

    // ------------------------------------------------------------------------
    // GF(2^8) arithmetic, field polynomial x^8 + x^4 + x^3 + x + 1
    // ------------------------------------------------------------------------

    function automatic logic [7:0] xtime(logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] cur;
        acc = 8'h00;
        cur = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ cur;
            end
            cur = xtime(cur);
        end
        return acc;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] prod;
        sq   = a;
        prod = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq   = gf_mul(sq, sq);        // a^(2^i)
            prod = gf_mul(prod, sq);
        end
        return prod;
    endfunction

    // Forward S-box: inverse, then the affine map with constant 0x63
    function automatic logic [7:0] sbox(logic [7:0] a);
        logic [7:0] inv;
        inv = gf_inv(a);
        return inv
             ^ {inv[6:0], inv[7]}
             ^ {inv[5:0], inv[7:6]}
             ^ {inv[4:0], inv[7:5]}
             ^ {inv[3:0], inv[7:4]}
             ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

// ==== design/aes_access_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_access_decode #(
    parameter logic [3:0] ACCESS_POLICY = 4'b0100
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire aes_pkg::token_t     agent_token,
    input  wire aes_pkg::block_t     plaintext,
    input  wire aes_pkg::block_t     key,
    input  wire                      start_encrypt,
    input  wire                      done,
    output aes_pkg::aes_req_t        issue_req,
    output logic                     issue,
    output logic                     busy
);

    aes_pkg::dec_state_e state_q;
    logic                can_accept;
    logic                accept;

    // A completing block frees the slot in the same cycle that done is seen
    assign can_accept = (state_q == aes_pkg::DEC_IDLE) || done;
    assign accept     = start_encrypt && ACCESS_POLICY[agent_token] && can_accept;
    assign busy       = (state_q == aes_pkg::DEC_BUSY) && !done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= aes_pkg::DEC_IDLE;
            issue   <= 1'b0;
        end else begin
            issue <= accept;                    // One cycle after the accepting edge
            if (accept) begin
                state_q <= aes_pkg::DEC_BUSY;
            end else if (done) begin
                state_q <= aes_pkg::DEC_IDLE;
            end
        end
    end

    // Request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_req.plaintext <= plaintext;
            issue_req.key       <= key;
        end
    end

endmodule

`default_nettype wire

// ==== design/aes_key_schedule.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_key_schedule (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  load,
    input  wire aes_pkg::block_t cipher_key,
    input  wire                  advance,
    output aes_pkg::block_t      round_key
);

    aes_pkg::block_t key_q;
    logic [7:0]      rcon_q;
    aes_pkg::word_t  w0, w1, w2, w3;
    aes_pkg::word_t  temp;
    aes_pkg::word_t  n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_q;

    // RotWord then SubWord on the last column, rcon into the top byte
    assign temp = {aes_pkg::sbox(w3[23:16]) ^ rcon_q,
                   aes_pkg::sbox(w3[15:8]),
                   aes_pkg::sbox(w3[7:0]),
                   aes_pkg::sbox(w3[31:24])};

    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};    // Key for the next round applied

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rcon_q <= aes_pkg::RCON_FIRST;
        end else if (load) begin
            rcon_q <= aes_pkg::RCON_FIRST;
        end else if (advance) begin
            rcon_q <= aes_pkg::xtime(rcon_q);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= cipher_key;
        end else if (advance) begin
            key_q <= round_key;
        end
    end

endmodule

`default_nettype wire

// ==== design/aes_round_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_round_engine (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    issue,
    input  wire aes_pkg::aes_req_t issue_req,
    output aes_pkg::block_t        final_state,
    output logic                   final_valid
);

    aes_pkg::eng_state_e         eng_state_q;
    logic [aes_pkg::ROUND_W-1:0] round_q;
    aes_pkg::block_t             state_q;
    aes_pkg::block_t             round_key;
    aes_pkg::block_t             shifted;
    aes_pkg::block_t             mixed;
    aes_pkg::block_t             round_out;
    logic                        start;
    logic                        advance;
    logic                        last_round;

    function automatic aes_pkg::word_t mix_column(aes_pkg::word_t col);
        logic [7:0] a0, a1, a2, a3;
        {a0, a1, a2, a3} = col;
        return {aes_pkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
                aes_pkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
                aes_pkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
                aes_pkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
    endfunction

    assign start      = issue && (eng_state_q == aes_pkg::ENG_IDLE);
    assign advance    = (eng_state_q == aes_pkg::ENG_ROUND);
    assign last_round = (round_q == aes_pkg::NUM_ROUNDS);

    aes_key_schedule i_aes_key_schedule (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (start),
        .cipher_key (issue_req.key),
        .advance    (advance),
        .round_key  (round_key)
    );

    // ------------------------------------------------------------------------
    // One full round, state held column-major with byte 0 at the top
    // ------------------------------------------------------------------------
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // SubBytes and ShiftRows together
                shifted[127 - 32*c - 8*r -: 8] =
                    aes_pkg::sbox(state_q[127 - 32*((c + r) % 4) - 8*r -: 8]);
            end
        end
        for (int c = 0; c < 4; c++) begin
            mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
        end
        round_out = (last_round ? shifted : mixed) ^ round_key;    // No MixColumns in round 10
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eng_state_q <= aes_pkg::ENG_IDLE;
            round_q     <= '0;
            final_valid <= 1'b0;
        end else begin
            final_valid <= 1'b0;
            case (eng_state_q)
                aes_pkg::ENG_IDLE: begin
                    if (start) begin
                        eng_state_q <= aes_pkg::ENG_ROUND;
                        round_q     <= 4'd1;
                    end
                end
                aes_pkg::ENG_ROUND: begin
                    round_q <= round_q + 4'd1;
                    if (last_round) begin
                        eng_state_q <= aes_pkg::ENG_IDLE;
                        final_valid <= 1'b1;
                    end
                end
                default: eng_state_q <= aes_pkg::ENG_IDLE;
            endcase
        end
    end

    // Round 0 is the initial AddRoundKey
    always_ff @(posedge clk) begin
        if (start) begin
            state_q <= issue_req.plaintext ^ issue_req.key;
        end else if (advance) begin
            state_q <= round_out;
        end
    end

    assign final_state = state_q;

endmodule

`default_nettype wire

// ==== design/aes_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_result (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  final_valid,
    input  wire aes_pkg::block_t final_state,
    input  wire                  issue,
    output aes_pkg::block_t      ciphertext,
    output logic                 done,
    output logic                 done_latched
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ciphertext   <= '0;
            done         <= 1'b0;
            done_latched <= 1'b0;
        end else begin
            done <= final_valid;                // Single-cycle pulse
            if (final_valid) begin
                ciphertext   <= final_state;
                done_latched <= 1'b1;
            end else if (issue) begin
                // New block under way, earlier completion no longer current
                done_latched <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/aes_soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_soc_top #(
    parameter logic [3:0] ACCESS_POLICY = 4'b0100    // One bit per token
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire aes_pkg::token_t agent_token,
    input  wire aes_pkg::block_t plaintext,
    input  wire aes_pkg::block_t key,
    input  wire                  start_encrypt,
    output aes_pkg::block_t      ciphertext,
    output logic                 busy,
    output logic                 done,
    output logic                 done_latched
);

    aes_pkg::aes_req_t issue_req;
    logic              issue;
    aes_pkg::block_t   final_state;
    logic              final_valid;

    // ------------------------------------------------------------------------
    // Decode, execute, result
    // ------------------------------------------------------------------------
    aes_access_decode #(
        .ACCESS_POLICY (ACCESS_POLICY)
    ) i_aes_access_decode (
        .clk           (clk),
        .arst_n        (arst_n),
        .agent_token   (agent_token),
        .plaintext     (plaintext),
        .key           (key),
        .start_encrypt (start_encrypt),
        .done          (done),
        .issue_req     (issue_req),
        .issue         (issue),
        .busy          (busy)
    );

    aes_round_engine i_aes_round_engine (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .issue_req   (issue_req),
        .final_state (final_state),
        .final_valid (final_valid)
    );

    aes_result i_aes_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .final_valid  (final_valid),
        .final_state  (final_state),
        .issue        (issue),
        .ciphertext   (ciphertext),
        .done         (done),
        .done_latched (done_latched)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/aes_soc_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_soc_sva (
    input wire clk,
    input wire arst_n,
    input wire start_encrypt,
    input wire issue,
    input wire busy,
    input wire done
);

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    // busy is released by the completion strobe and by nothing else
    busy_falls_on_done: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(done) |-> $fell(busy)
    ) else $error("done rose while busy did not fall");

    busy_falls_only_on_done: assert property (
        @(posedge clk) disable iff (!arst_n) $fell(busy) |-> $rose(done)
    ) else $error("busy fell without a done pulse");

    no_issue_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) (busy && start_encrypt) |=> !issue
    ) else $error("start during busy issued a new block");

endmodule

bind aes_soc_top aes_soc_sva i_aes_soc_sva (
    .clk           (clk),
    .arst_n        (arst_n),
    .start_encrypt (start_encrypt),
    .issue         (issue),
    .busy          (busy),
    .done          (done)
);

`default_nettype wire

// ==== bench/aes_soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_soc_tb;

    localparam logic [3:0] ACCESS_POLICY = 4'b0100;
    localparam int NUM_VECTORS  = 6;
    localparam int LATENCY      = 12;     // Accepting edge to done
    localparam int DONE_TIMEOUT = 40;
    localparam int DENY_WATCH   = 20;
    localparam int RESET_WAIT   = 20;

    typedef struct packed {
        aes_pkg::token_t token;
        aes_pkg::block_t plaintext;
        aes_pkg::block_t key;
        logic            expect_accept;
        aes_pkg::block_t expected_ct;     // Ciphertext seen after the entry
    } vector_t;

    wire             clk;
    wire             arst_n;
    aes_pkg::token_t agent_token;
    aes_pkg::block_t plaintext;
    aes_pkg::block_t key;
    logic            start_encrypt;
    wire aes_pkg::block_t ciphertext;
    wire             busy;
    wire             done;
    wire             done_latched;

    vector_t vectors [NUM_VECTORS];
    integer  seed;
    int      check_count;
    int      error_count;
    int      timeout_count;
    logic    latched_expect;              // High once a block has completed

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (3)
    ) i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    aes_soc_top #(
        .ACCESS_POLICY (ACCESS_POLICY)
    ) i_aes_soc_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .agent_token   (agent_token),
        .plaintext     (plaintext),
        .key           (key),
        .start_encrypt (start_encrypt),
        .ciphertext    (ciphertext),
        .busy          (busy),
        .done          (done),
        .done_latched  (done_latched)
    );

    // ------------------------------------------------------------------------
    // Compare helpers
    // ------------------------------------------------------------------------
    task automatic compare_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, got);
        end
    endtask

    task automatic compare_block(input string name, input aes_pkg::block_t got,
                                 input aes_pkg::block_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, got);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, got);
        end
    endtask

    task automatic draw_random_block(output aes_pkg::block_t value);
        aes_pkg::word_t w0, w1, w2, w3;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        value = {w0, w1, w2, w3};
    endtask

    // Known-answer vectors on token 2, denied tokens with random plaintexts
    task automatic load_vectors();
        aes_pkg::block_t r1, r3, r5;
        draw_random_block(r1);
        draw_random_block(r3);
        draw_random_block(r5);
        vectors[0] = {2'd2, 128'h3243f6a8885a308d313198a2e0370734,
                      128'h2b7e151628aed2a6abf7158809cf4f3c, 1'b1,
                      128'h3925841d02dc09fbdc118597196a0b32};
        vectors[1] = {2'd0, r1, 128'h2b7e151628aed2a6abf7158809cf4f3c, 1'b0,
                      128'h3925841d02dc09fbdc118597196a0b32};
        vectors[2] = {2'd2, 128'h00112233445566778899aabbccddeeff,
                      128'h000102030405060708090a0b0c0d0e0f, 1'b1,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vectors[3] = {2'd1, r3, 128'h000102030405060708090a0b0c0d0e0f, 1'b0,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vectors[4] = {2'd2, 128'h0, 128'h0, 1'b1, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
        vectors[5] = {2'd3, r5, 128'h0, 1'b0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
    endtask

    task automatic apply_accepted(input int idx);
        int cycles;
        cycles = 0;
        agent_token   = vectors[idx].token;
        plaintext     = vectors[idx].plaintext;
        key           = vectors[idx].key;
        start_encrypt = 1'b1;
        @(negedge clk);                   // Accepting edge has passed
        start_encrypt = 1'b0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            compare_bit("busy", busy, 1'b1);
            if (cycles >= 1) begin
                compare_bit("done_latched", done_latched, 1'b0);
            end
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            timeout_count++;
            $display("Timeout: no done within %0d cycles for vector %0d", DONE_TIMEOUT, idx);
        end else begin
            latched_expect = 1'b1;
            compare_count("latency", cycles, LATENCY);
            compare_block("ciphertext", ciphertext, vectors[idx].expected_ct);
            compare_bit("busy", busy, 1'b0);
            compare_bit("done_latched", done_latched, 1'b1);
            @(negedge clk);
            compare_bit("done", done, 1'b0);
            compare_bit("done_latched", done_latched, 1'b1);    // Idle, still latched
        end
    endtask

    // Start stays high for the whole watch window
    task automatic apply_denied(input int idx);
        agent_token    = vectors[idx].token;
        plaintext      = vectors[idx].plaintext;
        key            = vectors[idx].key;
        start_encrypt  = 1'b1;
        for (int i = 0; i < DENY_WATCH; i++) begin
            @(negedge clk);
            compare_bit("busy", busy, 1'b0);
            compare_bit("done", done, 1'b0);
            compare_bit("done_latched", done_latched, latched_expect);
            compare_block("ciphertext", ciphertext, vectors[idx].expected_ct);
        end
        start_encrypt = 1'b0;
    endtask

    task automatic apply_held_start();
        int cycles;
        int done_pulses;
        cycles        = 0;
        done_pulses   = 0;
        agent_token   = 2'd2;
        plaintext     = vectors[0].plaintext;
        key           = vectors[0].key;
        start_encrypt = 1'b1;
        @(negedge clk);
        // A second request shows up while the first is in flight
        plaintext = vectors[2].plaintext;
        key       = vectors[2].key;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        start_encrypt = 1'b0;
        if (done !== 1'b1) begin
            timeout_count++;
            $display("Timeout: no done within %0d cycles with start held high", DONE_TIMEOUT);
        end else begin
            done_pulses = 1;
            compare_count("latency", cycles, LATENCY);
            compare_block("ciphertext", ciphertext, vectors[0].expected_ct);
            for (int i = 0; i < DENY_WATCH; i++) begin
                @(negedge clk);
                if (done === 1'b1) begin
                    done_pulses++;
                end
                compare_bit("busy", busy, 1'b0);
            end
            compare_count("done pulses", done_pulses, 1);
            compare_block("ciphertext", ciphertext, vectors[0].expected_ct);
        end
    endtask

    initial begin
        int reset_wait;
        reset_wait     = 0;
        check_count    = 0;
        error_count    = 0;
        timeout_count  = 0;
        latched_expect = 1'b0;
        seed           = 32'hd0a5_294c;
        agent_token    = '0;
        plaintext      = '0;
        key            = '0;
        start_encrypt  = 1'b0;
        load_vectors();

        while (arst_n !== 1'b1 && reset_wait < RESET_WAIT) begin
            @(negedge clk);
            reset_wait++;
        end
        if (arst_n !== 1'b1) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk);
        compare_bit("busy", busy, 1'b0);
        compare_bit("done", done, 1'b0);
        compare_bit("done_latched", done_latched, 1'b0);
        compare_block("ciphertext", ciphertext, '0);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (vectors[i].expect_accept) begin
                apply_accepted(i);
            end else begin
                apply_denied(i);
            end
        end
        apply_held_start();

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/aes_pkg.sv
design/aes_access_decode.sv
design/aes_key_schedule.sv
design/aes_round_engine.sv
design/aes_result.sv
design/aes_soc_top.sv
bench/tb_clock_gen.sv
bench/aes_soc_sva.sv
bench/aes_soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AES testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=aes_soc_sim
log_file=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module aes_soc_tb \
    -Mdir "$build_dir" \
    -o "$sim_bin" \
    -f compile.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The verdict comes from the log, not from the exit status alone
if grep -qx "Testbench passed" "$log_file"; then
    echo "Result: PASS"
    exit 0
fi

echo "Result: FAIL"
exit 1
